// File: flist.f
hdl/lacore_pkg.sv
hdl/core_ctrl.sv
hdl/axi_mem_port.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/wb_result.sv
hdl/core_top.sv
bench/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_core -f flist.f -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output="$(./obj_dir/tb_core_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_output"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: bench/prog_stim.hex
// Header: program length in words, record count; then the program image from 1c000000.
// Records: 1 pc reg value (write-back) or 2 addr data 0 (store), in retirement order.
00000021 00000017
14380001 02880021 02bfec02 02848c03  // lu12i, addi, addi -5, addi
15579bc4 02bffc84 00100c45 00110c46  // lu12i, addi -1, add, sub
00148887 00151868 00159489 00120c4a  // and, or, xor, slt
0012086b 00100c60 00150c0c 29801029  // slt, add to r0, or from r0, st
2880102d 580009a9 0280040e 5c0009a9  // ld, beq taken, skipped, bne not taken
029ffc0f 5c0009e3 02800810 5800086f  // addi, bne taken, skipped, beq not taken
02a00011 58000c00 02815412 58000c00  // addi -2048, beq fwd, addi, beq fwd
142468b3 5bfff673 29802033 28802034  // lu12i, beq back, st, ld
ffffffff                             // illegal word
1 1c000000 01 1c000000
1 1c000004 01 1c000200
1 1c000008 02 fffffffb
1 1c00000c 03 00000123
1 1c000010 04 abcde000
1 1c000014 04 abcddfff
1 1c000018 05 0000011e
1 1c00001c 06 fffffed8
1 1c000020 07 abcddffb
1 1c000024 08 fffffffb
1 1c000028 09 abcddee1
1 1c00002c 0a 00000001
1 1c000030 0b 00000000
1 1c000034 00 00000246
1 1c000038 0c 00000123
2 1c000204 abcddee1 0
1 1c000040 0d abcddee1
1 1c000050 0f 000007ff
1 1c000060 11 fffff800
1 1c000070 13 12345000
1 1c000068 12 00000055
2 1c000208 12345000 0
1 1c00007c 14 12345000

// File: bench/tb_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_core import lacore_pkg::*; ();

  localparam word_t MEM_BASE = 32'h1c00_0000;
  localparam word_t MEM_BYTES = 32'h0000_0400;
  localparam int MEM_WORDS = 256;
  localparam int CYCLES_PER_RECORD = 40;

  logic       aclk;
  logic       rst;
  word_t      araddr;
  logic [2:0] arprot;
  logic       arvalid;
  logic       arready;
  word_t      rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  word_t      awaddr;
  logic [2:0] awprot;
  logic       awvalid;
  logic       awready;
  word_t      wdata;
  logic [3:0] wstrb;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  word_t      debug_wb_pc;
  logic [3:0] debug_wb_rf_wen;
  reg_idx_t   debug_wb_rf_wnum;
  word_t      debug_wb_rf_wdata;
  logic       halted;

  word_t    mem [MEM_WORDS];
  word_t    stim [256];
  word_t    wb_pc_q [$];
  reg_idx_t wb_num_q [$];
  word_t    wb_data_q [$];
  word_t    st_addr_q [$];
  word_t    st_data_q [$];
  word_t    prog_end;
  int       cycle_limit;
  int       cycles;

  // Slave model state.
  logic  r_pending;
  logic  aw_got;
  logic  w_got;
  logic  b_pending;
  int    ar_delay;
  int    r_delay;
  int    aw_delay;
  int    w_delay;
  int    b_delay;
  word_t r_addr;
  word_t st_addr;
  word_t st_data;

  core_top #(
    .RESET_PC(MEM_BASE)
  ) core_top_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input word_t expected, input word_t actual);
    stop_run($sformatf("CHECK FAILED at %0d ns: %s expected %h, got %h",
                       $time, sig, expected, actual));
  endtask

  task automatic check_field(input string sig, input logic [3:0] expected,
                             input logic [3:0] actual);
    if (actual !== expected) begin
      report_mismatch(sig, {28'b0, expected}, {28'b0, actual});
    end
  endtask

  task automatic check_wb(input word_t pc, input reg_idx_t num, input word_t data);
    if (wb_pc_q.size() == 0) begin
      stop_run($sformatf("Unexpected write-back to r%0d at %0d ns with no record left",
                         num, $time));
    end else begin
      if (pc !== wb_pc_q[0]) begin
        report_mismatch("debug_wb_pc", wb_pc_q[0], pc);
      end
      if (num !== wb_num_q[0]) begin
        report_mismatch("debug_wb_rf_wnum", {27'b0, wb_num_q[0]}, {27'b0, num});
      end
      if (data !== wb_data_q[0]) begin
        report_mismatch("debug_wb_rf_wdata", wb_data_q[0], data);
      end
      void'(wb_pc_q.pop_front());
      void'(wb_num_q.pop_front());
      void'(wb_data_q.pop_front());
    end
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    if (st_addr_q.size() == 0) begin
      stop_run($sformatf("Unexpected AXI write to %h at %0d ns", addr, $time));
    end else begin
      if (addr !== st_addr_q[0]) begin
        report_mismatch("awaddr", st_addr_q[0], addr);
      end
      if (data !== st_data_q[0]) begin
        report_mismatch("wdata", st_data_q[0], data);
      end
      void'(st_addr_q.pop_front());
      void'(st_data_q.pop_front());
    end
  endtask

  function automatic int pick_delay();
    return $urandom_range(3, 0);
  endfunction

  function automatic bit in_memory(input word_t addr);
    return (addr >= MEM_BASE) && (addr < MEM_BASE + MEM_BYTES);
  endfunction

  function automatic logic [7:0] word_index(input word_t addr);
    word_t offset;
    offset = addr - MEM_BASE;
    return offset[9:2];
  endfunction

  function automatic int records_left();
    return wb_pc_q.size() + st_addr_q.size();
  endfunction

  // The response goes first so it never shares a cycle with its own address.
  task automatic serve_read();
    rvalid = 1'b0;
    if (r_pending) begin
      if (r_delay > 0) begin
        r_delay--;
      end else begin
        rvalid = 1'b1;
        rdata  = in_memory(r_addr) ? mem[word_index(r_addr)] : 32'h0;
        rresp  = in_memory(r_addr) ? 2'b00 : 2'b10;
        if (rready) begin
          r_pending = 1'b0;
        end
      end
    end
    arready = 1'b0;
    if (arvalid && !r_pending) begin
      if (ar_delay > 0) begin
        ar_delay--;
      end else begin
        arready   = 1'b1;
        r_addr    = araddr;
        // Fetches come from the program image, loads from beyond it.
        check_field("arprot", (araddr >= MEM_BASE && araddr < prog_end) ? 4'h4 : 4'h0,
                    {1'b0, arprot});
        r_pending = 1'b1;
        r_delay   = pick_delay();
        ar_delay  = pick_delay();
      end
    end
  endtask

  task automatic serve_write();
    bvalid = 1'b0;
    if (b_pending) begin
      if (b_delay > 0) begin
        b_delay--;
      end else begin
        bvalid = 1'b1;
        bresp  = in_memory(st_addr) ? 2'b00 : 2'b10;
        if (bready) begin
          b_pending = 1'b0;
        end
      end
    end
    awready = 1'b0;
    if (awvalid && !aw_got) begin
      if (aw_delay > 0) begin
        aw_delay--;
      end else begin
        awready  = 1'b1;
        aw_got   = 1'b1;
        st_addr  = awaddr;
        check_field("awprot", 4'h0, {1'b0, awprot});
        aw_delay = pick_delay();
      end
    end
    wready = 1'b0;
    if (wvalid && !w_got) begin
      if (w_delay > 0) begin
        w_delay--;
      end else begin
        wready  = 1'b1;
        w_got   = 1'b1;
        st_data = wdata;
        check_field("wstrb", 4'hf, wstrb);
        w_delay = pick_delay();
      end
    end
    if (aw_got && w_got) begin
      aw_got = 1'b0;
      w_got  = 1'b0;
      check_store(st_addr, st_data);
      if (in_memory(st_addr)) begin
        mem[word_index(st_addr)] = st_data;
      end
      b_pending = 1'b1;
      b_delay   = pick_delay();
    end
  endtask

  task automatic watch_retire();
    if (debug_wb_rf_wen != 4'h0) begin
      check_field("debug_wb_rf_wen", 4'hf, debug_wb_rf_wen);
      check_wb(debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
    end
    if (halted && records_left() != 0) begin
      stop_run($sformatf("Core halted at %0d ns with %0d records still expected",
                         $time, records_left()));
    end
  endtask

  initial begin
    logic [7:0] at;
    int         post_halt;
    rst     = 1'b1;
    arready = 1'b0;
    rdata   = 32'h0;
    rresp   = 2'b00;
    rvalid  = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    bresp   = 2'b00;
    bvalid  = 1'b0;
    void'($urandom(84500));
    for (int i = 0; i < 256; i++) begin
      stim[i] = 32'h0;
    end
    $readmemh("bench/prog_stim.hex", stim);
    if (stim[0] == 32'h0 || stim[1] == 32'h0 || stim[0] > 32'd64) begin
      stop_run("Stim file is missing or has a bad header");
    end
    prog_end    = MEM_BASE + (stim[0] << 2);
    cycle_limit = int'(stim[1]) * CYCLES_PER_RECORD;
    // Unused words hold a pattern built from their own address.
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = ~(MEM_BASE + 32'(i) * 32'd4);
    end
    for (int i = 0; i < int'(stim[0]); i++) begin
      mem[i] = stim[i + 2];
    end
    at = 8'(stim[0] + 32'd2);
    for (int n = 0; n < int'(stim[1]); n++) begin
      if (stim[at] == 32'd1) begin
        wb_pc_q.push_back(stim[at + 8'd1]);
        wb_num_q.push_back(stim[at + 8'd2][4:0]);
        wb_data_q.push_back(stim[at + 8'd3]);
      end else if (stim[at] == 32'd2) begin
        st_addr_q.push_back(stim[at + 8'd1]);
        st_data_q.push_back(stim[at + 8'd2]);
      end else begin
        stop_run($sformatf("Record %0d in the stim file has an unknown kind", n));
      end
      at = at + 8'd4;
    end
    r_pending = 1'b0;
    aw_got    = 1'b0;
    w_got     = 1'b0;
    b_pending = 1'b0;
    ar_delay  = pick_delay();
    aw_delay  = pick_delay();
    w_delay   = pick_delay();
    repeat (10) @(posedge aclk);
    #1;
    rst       = 1'b0;
    cycles    = 0;
    post_halt = 0;
    // A few idle cycles after the halt catch any late write-back.
    while (post_halt < 10) begin
      @(posedge aclk);
      #1;
      serve_read();
      serve_write();
      watch_retire();
      cycles++;
      if (halted && records_left() == 0) begin
        post_halt++;
      end else if (cycles > cycle_limit) begin
        stop_run($sformatf("Timeout after %0d cycles: the core stopped retiring instructions",
                           cycles));
      end
    end
    if (halted && records_left() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_run("Run ended with records still unmatched");
    end
  end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`default_nettype none
`timescale 1ns/1ps

module core_top import lacore_pkg::*; #(
  parameter word_t RESET_PC = 32'h1c00_0000
) (
  input  logic       aclk,
  input  logic       rst,
  // Read address and data.
  output word_t      araddr,
  output logic [2:0] arprot,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      rdata,
  input  logic [1:0] rresp,
  input  logic       rvalid,
  output logic       rready,
  // Write address, data and response.
  output word_t      awaddr,
  output logic [2:0] awprot,
  output logic       awvalid,
  input  logic       awready,
  output word_t      wdata,
  output logic [3:0] wstrb,
  output logic       wvalid,
  input  logic       wready,
  input  logic [1:0] bresp,
  input  logic       bvalid,
  output logic       bready,
  // Retirement trace.
  output word_t      debug_wb_pc,
  output logic [3:0] debug_wb_rf_wen,
  output reg_idx_t   debug_wb_rf_wnum,
  output word_t      debug_wb_rf_wdata,
  output logic       halted
);

  logic     req_valid;
  logic     req_write;
  logic     req_fetch;
  word_t    req_addr;
  logic     mem_done;
  word_t    mem_rdata;
  logic     mem_err;
  inst_u    inst;
  phase_e   phase;
  word_t    pc;
  op_e      op;
  reg_idx_t rd;
  reg_idx_t rj;
  reg_idx_t rk;
  word_t    imm;
  logic     writes_rd;
  word_t    rj_val;
  word_t    rk_val;
  word_t    exec_result;
  logic     branch_taken;
  word_t    branch_target;

  core_ctrl #(
    .RESET_PC(RESET_PC)
  ) core_ctrl_inst (
    .aclk          (aclk),
    .rst           (rst),
    .mem_done      (mem_done),
    .mem_rdata     (mem_rdata),
    .mem_err       (mem_err),
    .op            (op),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .exec_result   (exec_result),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_fetch     (req_fetch),
    .req_addr      (req_addr),
    .inst          (inst),
    .phase         (phase),
    .pc            (pc),
    .halted        (halted)
  );

  // Store data comes straight from the rk read port.
  axi_mem_port axi_mem_port_inst (
    .aclk      (aclk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_fetch (req_fetch),
    .req_addr  (req_addr),
    .req_wdata (rk_val),
    .done      (mem_done),
    .rdata_out (mem_rdata),
    .err       (mem_err),
    .araddr    (araddr),
    .arprot    (arprot),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awprot    (awprot),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  inst_decode inst_decode_inst (
    .inst      (inst),
    .op        (op),
    .rd        (rd),
    .rj        (rj),
    .rk        (rk),
    .imm       (imm),
    .writes_rd (writes_rd)
  );

  alu_execute alu_execute_inst (
    .aclk          (aclk),
    .rst           (rst),
    .phase         (phase),
    .op            (op),
    .rj_val        (rj_val),
    .rk_val        (rk_val),
    .imm           (imm),
    .pc            (pc),
    .result        (exec_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  wb_result wb_result_inst (
    .aclk              (aclk),
    .rst               (rst),
    .phase             (phase),
    .op                (op),
    .writes_rd         (writes_rd),
    .rd                (rd),
    .rj                (rj),
    .rk                (rk),
    .exec_result       (exec_result),
    .load_data         (mem_rdata),
    .pc                (pc),
    .rj_val            (rj_val),
    .rk_val            (rk_val),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_wen   (debug_wb_rf_wen),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
  );

endmodule

`default_nettype wire

// File: hdl/wb_result.sv
`default_nettype none
`timescale 1ns/1ps

module wb_result import lacore_pkg::*; (
  input  logic     aclk,
  input  logic     rst,
  input  phase_e   phase,
  input  op_e      op,
  input  logic     writes_rd,
  input  reg_idx_t rd,
  input  reg_idx_t rj,
  input  reg_idx_t rk,
  input  word_t    exec_result,
  input  word_t    load_data,
  input  word_t    pc,
  output word_t    rj_val,
  output word_t    rk_val,
  output word_t    debug_wb_pc,
  output logic [3:0] debug_wb_rf_wen,
  output reg_idx_t debug_wb_rf_wnum,
  output word_t    debug_wb_rf_wdata
);

  word_t rf [32];
  word_t wb_data;
  logic  wb_fire;

  assign wb_fire = (phase == PH_RESULT) && writes_rd;
  assign wb_data = (op == OP_LD) ? load_data : exec_result;

  // r0 is never stored.
  always_ff @(posedge aclk) begin
    if (wb_fire && rd != 5'd0) begin
      rf[rd] <= wb_data;
    end
  end

  assign rj_val = (rj == 5'd0) ? 32'h0 : rf[rj];
  assign rk_val = (rk == 5'd0) ? 32'h0 : rf[rk];

  // Writes to r0 still show up in the trace
  assign debug_wb_pc       = pc;
  assign debug_wb_rf_wen   = {4{wb_fire}};
  assign debug_wb_rf_wnum  = rd;
  assign debug_wb_rf_wdata = wb_data;

  // One trace pulse per retirement.
  assert property (@(posedge aclk) disable iff (rst)
    (|debug_wb_rf_wen) |=> (debug_wb_rf_wen == 4'h0));

endmodule

`default_nettype wire

// File: hdl/alu_execute.sv
`default_nettype none
`timescale 1ns/1ps

module alu_execute import lacore_pkg::*; (
  input  logic   aclk,
  input  logic   rst,
  input  phase_e phase,
  input  op_e    op,
  input  word_t  rj_val,
  input  word_t  rk_val,
  input  word_t  imm,
  input  word_t  pc,
  output word_t  result,
  output logic   branch_taken,
  output word_t  branch_target
);

  word_t operand_b;
  word_t alu_out;
  logic  equal;

  // addi.w, ld.w and st.w take the immediate as the second operand.
  assign operand_b = (op == OP_ADDI || op == OP_LD || op == OP_ST) ? imm : rk_val;
  assign equal     = (rj_val == rk_val);

  always_comb begin
    case (op)
      OP_SUB:   alu_out = rj_val - operand_b;
      OP_AND:   alu_out = rj_val & operand_b;
      OP_OR:    alu_out = rj_val | operand_b;
      OP_XOR:   alu_out = rj_val ^ operand_b;
      OP_SLT:   alu_out = {31'b0, $signed(rj_val) < $signed(operand_b)};
      OP_LU12I: alu_out = imm;
      default:  alu_out = rj_val + operand_b;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (phase == PH_EXEC) begin
      result <= alu_out;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      branch_taken <= 1'b0;
    end else if (phase == PH_EXEC) begin
      branch_taken <= (op == OP_BEQ && equal) || (op == OP_BNE && !equal);
    end
  end

  // Offset counts words.
  assign branch_target = pc + {imm[29:0], 2'b00};

endmodule

`default_nettype wire

// File: hdl/inst_decode.sv
`default_nettype none
`timescale 1ns/1ps

module inst_decode import lacore_pkg::*; (
  input  inst_u    inst,
  output op_e      op,
  output reg_idx_t rd,
  output reg_idx_t rj,
  output reg_idx_t rk,
  output word_t    imm,
  output logic     writes_rd
);

  logic [19:0] si20;
  logic [15:0] offs16;

  // lu12i.w and branches reach into the opcode bits for their immediates.
  assign si20   = {inst.fmt_imm.opcode[2:0], inst.fmt_imm.imm, inst.fmt_imm.rj};
  assign offs16 = {inst.fmt_imm.opcode[3:0], inst.fmt_imm.imm};

  always_comb begin
    op = OP_ILLEGAL;
    case (inst.fmt_3r.opcode)
      OPC_ADD_W: op = OP_ADD;
      OPC_SUB_W: op = OP_SUB;
      OPC_AND:   op = OP_AND;
      OPC_OR:    op = OP_OR;
      OPC_XOR:   op = OP_XOR;
      OPC_SLT:   op = OP_SLT;
      default:   ;
    endcase
    case (inst.fmt_imm.opcode)
      OPC_ADDI_W: op = OP_ADDI;
      OPC_LD_W:   op = OP_LD;
      OPC_ST_W:   op = OP_ST;
      default:    ;
    endcase
    if (inst.fmt_imm.opcode[9:3] == OPC_LU12I_W) begin
      op = OP_LU12I;
    end
    if (inst.fmt_imm.opcode[9:4] == OPC_BEQ) begin
      op = OP_BEQ;
    end
    if (inst.fmt_imm.opcode[9:4] == OPC_BNE) begin
      op = OP_BNE;
    end
  end

  always_comb begin
    case (op)
      OP_LU12I:       imm = {si20, 12'h000};
      OP_BEQ, OP_BNE: imm = {{16{offs16[15]}}, offs16};
      default:        imm = {{20{inst.fmt_imm.imm[11]}}, inst.fmt_imm.imm};
    endcase
  end

  assign rd = inst.fmt_3r.rd;
  assign rj = inst.fmt_3r.rj;

  // Stores and branches read rd as their second source.
  assign rk = (op == OP_ST || op == OP_BEQ || op == OP_BNE) ? inst.fmt_3r.rd : inst.fmt_3r.rk;

  always_comb begin
    case (op)
      OP_ST, OP_BEQ, OP_BNE, OP_ILLEGAL: writes_rd = 1'b0;
      default:                           writes_rd = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/axi_mem_port.sv
`default_nettype none
`timescale 1ns/1ps

module axi_mem_port import lacore_pkg::*; (
  input  logic       aclk,
  input  logic       rst,
  input  logic       req_valid,
  input  logic       req_write,
  input  logic       req_fetch,
  input  word_t      req_addr,
  input  word_t      req_wdata,
  output logic       done,
  output word_t      rdata_out,
  output logic       err,
  output word_t      araddr,
  output logic [2:0] arprot,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      rdata,
  input  logic [1:0] rresp,
  input  logic       rvalid,
  output logic       rready,
  output word_t      awaddr,
  output logic [2:0] awprot,
  output logic       awvalid,
  input  logic       awready,
  output word_t      wdata,
  output logic [3:0] wstrb,
  output logic       wvalid,
  input  logic       wready,
  input  logic [1:0] bresp,
  input  logic       bvalid,
  output logic       bready
);

  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_AR   = 3'd1;
  localparam logic [2:0] ST_R    = 3'd2;
  localparam logic [2:0] ST_WR   = 3'd3;
  localparam logic [2:0] ST_B    = 3'd4;
  localparam logic [2:0] ST_DONE = 3'd5;

  logic [2:0] state;
  logic       accept;
  logic       in_flight;
  logic       aw_clear;
  logic       w_clear;

  assign accept    = (state == ST_IDLE) && req_valid;
  assign in_flight = (state != ST_IDLE) && (state != ST_DONE);
  assign done      = (state == ST_DONE);
  assign wstrb     = 4'hf;
  assign awprot    = 3'b000;

  // Each write channel is finished once its valid is gone or being taken.
  assign aw_clear = !awvalid || awready;
  assign w_clear  = !wvalid || wready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      state   <= ST_IDLE;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      err     <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept && req_write) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= ST_WR;
          end else if (accept) begin
            arvalid <= 1'b1;
            state   <= ST_AR;
          end
        end
        ST_AR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= ST_R;
          end
        end
        ST_R: begin
          if (rvalid) begin
            rready <= 1'b0;
            err    <= (rresp != 2'b00);
            state  <= ST_DONE;
          end
        end
        ST_WR: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (aw_clear && w_clear) begin
            bready <= 1'b1;
            state  <= ST_B;
          end
        end
        ST_B: begin
          if (bvalid) begin
            bready <= 1'b0;
            err    <= (bresp != 2'b00);
            state  <= ST_DONE;
          end
        end
        // Done lasts one cycle.
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      araddr <= req_addr;
      awaddr <= req_addr;
      wdata  <= req_wdata;
      arprot <= req_fetch ? 3'b100 : 3'b000;
    end
    if (state == ST_R && rvalid) begin
      rdata_out <= rdata;
    end
  end

  assert property (@(posedge aclk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr));

  // The requester keeps its request up and steady until done.
  assert property (@(posedge aclk) disable iff (rst)
    in_flight |-> req_valid && $stable(req_addr));

endmodule

`default_nettype wire

// File: hdl/core_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module core_ctrl import lacore_pkg::*; #(
  parameter word_t RESET_PC = 32'h1c00_0000
) (
  input  logic   aclk,
  input  logic   rst,
  input  logic   mem_done,
  input  word_t  mem_rdata,
  input  logic   mem_err,
  input  op_e    op,
  input  logic   branch_taken,
  input  word_t  branch_target,
  input  word_t  exec_result,
  output logic   req_valid,
  output logic   req_write,
  output logic   req_fetch,
  output word_t  req_addr,
  output inst_u  inst,
  output phase_e phase,
  output word_t  pc,
  output logic   halted
);

  logic is_mem_op;

  assign is_mem_op = (op == OP_LD) || (op == OP_ST);

  // Once halted, the phase freezes and no request goes out.
  always_ff @(posedge aclk) begin
    if (rst) begin
      phase  <= PH_FETCH;
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      case (phase)
        PH_FETCH: begin
          if (mem_done) begin
            if (mem_err) begin
              halted <= 1'b1;
            end else begin
              phase <= PH_DECODE;
            end
          end
        end
        PH_DECODE: begin
          if (op == OP_ILLEGAL) begin
            halted <= 1'b1;
          end else begin
            phase <= PH_EXEC;
          end
        end
        PH_EXEC: phase <= is_mem_op ? PH_MEM : PH_RESULT;
        PH_MEM: begin
          if (mem_done) begin
            if (mem_err) begin
              halted <= 1'b1;
            end else begin
              phase <= PH_RESULT;
            end
          end
        end
        PH_RESULT: begin
          pc    <= branch_taken ? branch_target : pc + 32'd4;
          phase <= PH_FETCH;
        end
        default: phase <= PH_FETCH;
      endcase
    end
  end

  // Instruction register.
  always_ff @(posedge aclk) begin
    if (phase == PH_FETCH && mem_done) begin
      inst <= mem_rdata;
    end
  end

  assign req_fetch = (phase == PH_FETCH);
  assign req_valid = !halted && (phase == PH_FETCH || phase == PH_MEM);
  assign req_write = (phase == PH_MEM) && (op == OP_ST);
  assign req_addr  = req_fetch ? pc : exec_result;

  // Both the PC and the computed ld/st address must be word aligned.
  assert property (@(posedge aclk) disable iff (rst)
    req_valid |-> (req_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: hdl/lacore_pkg.sv
`default_nettype none

package lacore_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_ADDI,
    OP_LU12I,
    OP_LD,
    OP_ST,
    OP_BEQ,
    OP_BNE,
    OP_ILLEGAL
  } op_e;

  typedef enum logic [2:0] {
    PH_FETCH,
    PH_DECODE,
    PH_EXEC,
    PH_MEM,
    PH_RESULT
  } phase_e;

  // Two views of the same instruction word.
  typedef union packed {
    struct packed {
      logic [16:0] opcode;
      reg_idx_t    rk;
      reg_idx_t    rj;
      reg_idx_t    rd;
    } fmt_3r;
    struct packed {
      logic [9:0]  opcode;
      logic [11:0] imm;
      reg_idx_t    rj;
      reg_idx_t    rd;
    } fmt_imm;
  } inst_u;

  // Register forms, bits [31:15].
  localparam logic [16:0] OPC_ADD_W = 17'h00020;
  localparam logic [16:0] OPC_SUB_W = 17'h00022;
  localparam logic [16:0] OPC_SLT   = 17'h00024;
  localparam logic [16:0] OPC_AND   = 17'h00029;
  localparam logic [16:0] OPC_OR    = 17'h0002a;
  localparam logic [16:0] OPC_XOR   = 17'h0002b;

  // si12 forms, bits [31:22].
  localparam logic [9:0] OPC_ADDI_W = 10'h00a;
  localparam logic [9:0] OPC_LD_W   = 10'h0a2;
  localparam logic [9:0] OPC_ST_W   = 10'h0a6;

  // Wider immediates leave fewer opcode bits.
  localparam logic [6:0] OPC_LU12I_W = 7'h0a;
  localparam logic [5:0] OPC_BEQ     = 6'h16;
  localparam logic [5:0] OPC_BNE     = 6'h17;

endpackage

`default_nettype wire
